//--- rtl/dsi_tx_config.svh
`ifndef DSI_TX_CONFIG_SVH
`define DSI_TX_CONFIG_SVH

// lane geometry
`define DSI_MAX_LANES     4
`define DSI_PIX_WIDTH     32        // input stream word
`define DSI_BYTE_WIDTH    8
`define DSI_FIFO_DEPTH    32        // bytes per lane
`define DSI_TIMER_WIDTH   8

// wishbone word addresses
`define DSI_REG_CTRL      2'd0
`define DSI_REG_TLPX      2'd1
`define DSI_REG_TRAIL     2'd2
`define DSI_REG_STATUS    2'd3      // read only

// timing defaults, clk_sys cycles
`define DSI_TLPX_RESET    8'd4
`define DSI_TRAIL_RESET   8'd6

`endif

//--- rtl/dsi_tx_pkg.sv
`include "dsi_tx_config.svh"

package dsi_tx_pkg;

    typedef logic [`DSI_PIX_WIDTH-1:0]                 pix_word_t;   // byte 0 in low bits
    typedef logic [`DSI_BYTE_WIDTH-1:0]                lane_byte_t;
    typedef logic [`DSI_MAX_LANES-1:0]                 lane_mask_t;  // one bit per lane
    typedef logic [`DSI_MAX_LANES*`DSI_BYTE_WIDTH-1:0] hs_bus_t;     // lane 0 in low byte
    typedef logic [`DSI_TIMER_WIDTH-1:0]               timer_t;

    typedef enum logic [1:0] {
        LANES_1 = 2'd0,
        LANES_2 = 2'd1,
        LANES_4 = 2'd2        // code 3 decodes as four lanes too
    } lane_code_t;

    typedef enum logic [2:0] {
        ST_STOP     = 3'd0,   // LP-11
        ST_HS_RQST  = 3'd1,   // LP-01
        ST_HS_PREP  = 3'd2,   // LP-00
        ST_HS_SEND  = 3'd3,
        ST_HS_TRAIL = 3'd4
    } lane_state_t;

endpackage

//--- rtl/dsi_tx_regs.sv
`include "dsi_tx_config.svh"

module dsi_tx_regs
    import dsi_tx_pkg::*;
(
    input  logic        clk_sys,
    input  logic        rst_n,

    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic        wb_we,
    input  logic [1:0]  wb_adr,
    input  logic [31:0] wb_dat_w,
    output logic [31:0] wb_dat_r,
    output logic        wb_ack,

    input  lane_state_t lane_state,
    output logic        enable,
    output lane_code_t  lane_code,
    output timer_t      tlpx,
    output timer_t      trail
);

    logic        wb_req;      // access pending, ack not yet given
    logic [31:0] rd_data;

    assign wb_req = wb_cyc && wb_stb && !wb_ack;

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= wb_req;
        end
    end

    // write side, lands on the edge that raises ack
    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            enable    <= 1'b0;
            lane_code <= LANES_4;
            tlpx      <= `DSI_TLPX_RESET;
            trail     <= `DSI_TRAIL_RESET;
        end else if (wb_req && wb_we) begin
            case (wb_adr)
                `DSI_REG_CTRL: begin
                    enable    <= wb_dat_w[0];
                    lane_code <= lane_code_t'(wb_dat_w[2:1]);
                end
                `DSI_REG_TLPX:  tlpx  <= wb_dat_w[`DSI_TIMER_WIDTH-1:0];
                `DSI_REG_TRAIL: trail <= wb_dat_w[`DSI_TIMER_WIDTH-1:0];
                default: ;    // status ignores writes
            endcase
        end
    end

    always_comb begin
        rd_data = '0;
        case (wb_adr)
            `DSI_REG_CTRL:  rd_data[2:0] = {lane_code, enable};
            `DSI_REG_TLPX:  rd_data[`DSI_TIMER_WIDTH-1:0] = tlpx;
            `DSI_REG_TRAIL: rd_data[`DSI_TIMER_WIDTH-1:0] = trail;
            default:        rd_data[2:0] = lane_state;
        endcase
    end

    always_ff @(posedge clk_sys) begin
        if (wb_req && !wb_we) begin
            wb_dat_r <= rd_data;  // held with ack
        end
    end

    // one ack per access, even though the master drops stb a cycle late
    assert property (@(posedge clk_sys) disable iff (!rst_n) wb_ack |=> !wb_ack);

endmodule

//--- rtl/dsi_byte_distributor.sv
`include "dsi_tx_config.svh"

module dsi_byte_distributor
    import dsi_tx_pkg::*;
(
    input  logic       clk_sys,
    input  logic       rst_n,

    input  pix_word_t  pix_data,
    input  logic       pix_valid,
    output logic       pix_ready,

    input  lane_code_t lane_code,

    output hs_bus_t    fifo_wdata,
    output lane_mask_t fifo_push,
    input  lane_mask_t fifo_full
);

    pix_word_t  held_word;
    logic       held;         // word waiting to be spread
    logic [1:0] grp;          // byte group inside held word
    logic [1:0] last_grp;
    logic [2:0] num_lanes;
    lane_mask_t act_mask;
    logic [2:0] base;         // first byte of current group
    logic       blocked;
    logic       issue;
    logic       take;

    always_comb begin
        case (lane_code)
            LANES_1: begin
                num_lanes = 3'd1;
                last_grp  = 2'd3;
                act_mask  = 4'b0001;
            end
            LANES_2: begin
                num_lanes = 3'd2;
                last_grp  = 2'd1;
                act_mask  = 4'b0011;
            end
            default: begin
                num_lanes = 3'd4;
                last_grp  = 2'd0;
                act_mask  = 4'b1111;
            end
        endcase
    end

    assign blocked   = |(fifo_full & act_mask);
    assign issue     = held && !blocked;
    assign pix_ready = !blocked && (!held || grp == last_grp);
    assign take      = pix_valid && pix_ready;
    assign fifo_push = issue ? act_mask : '0;
    assign base      = {1'b0, grp} * num_lanes;

    // byte base+j of the held word goes to lane j
    always_comb begin
        fifo_wdata = '0;
        for (int j = 0; j < `DSI_MAX_LANES; j++) begin
            if (act_mask[j]) begin
                fifo_wdata[j*`DSI_BYTE_WIDTH +: `DSI_BYTE_WIDTH] =
                    held_word[(int'(base) + j)*`DSI_BYTE_WIDTH +: `DSI_BYTE_WIDTH];
            end
        end
    end

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            held <= 1'b0;
            grp  <= 2'd0;
        end else if (take) begin
            held <= 1'b1;     // may replace a word finishing this cycle
            grp  <= 2'd0;
        end else if (issue) begin
            if (grp == last_grp) begin
                held <= 1'b0;
                grp  <= 2'd0;
            end else begin
                grp <= grp + 2'd1;
            end
        end
    end

    always_ff @(posedge clk_sys) begin
        if (take) begin
            held_word <= pix_data;
        end
    end

    assert property (@(posedge clk_sys) disable iff (!rst_n) (fifo_push & fifo_full) == '0);

endmodule

//--- rtl/dsi_lane_fifo.sv
`include "dsi_tx_config.svh"

module dsi_lane_fifo
    import dsi_tx_pkg::*;
(
    input  logic       clk_sys,
    input  logic       rst_n,

    input  lane_byte_t wdata,
    input  logic       push,
    output logic       full,

    output lane_byte_t rdata,
    input  logic       pop,
    output logic       empty
);

    localparam int DEPTH = `DSI_FIFO_DEPTH;
    localparam int AW    = $clog2(DEPTH);
    localparam int CW    = $clog2(DEPTH + 1);

    lane_byte_t    mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic          do_push;
    logic          do_pop;

    assign do_push = push && !full;
    assign do_pop  = pop && !empty;
    assign full    = (count == CW'(DEPTH));
    assign empty   = (count == '0);
    assign rdata   = mem[rd_ptr];     // head byte shows without a pop

    always_ff @(posedge clk_sys) begin
        if (do_push) begin
            mem[wr_ptr] <= wdata;
        end
    end

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;    // both or neither, level unchanged
            endcase
        end
    end

    // controller only pops lanes it has seen non-empty
    assert property (@(posedge clk_sys) disable iff (!rst_n) pop |-> !empty);

endmodule

//--- rtl/dsi_lanes_controller.sv
module dsi_lanes_controller
    import dsi_tx_pkg::*;
(
    input  logic        clk_sys,
    input  logic        rst_n,

    input  logic        enable,
    input  lane_code_t  lane_code,
    input  timer_t      tlpx,
    input  timer_t      trail,

    input  hs_bus_t     fifo_rdata,
    input  lane_mask_t  fifo_empty,
    output lane_mask_t  fifo_pop,

    output lane_state_t lane_state,
    output hs_bus_t     hs_data,
    output lane_mask_t  hs_valid,
    output lane_mask_t  lp_p,
    output lane_mask_t  lp_n
);

    lane_state_t state;
    lane_state_t state_next;
    timer_t      timer;
    timer_t      timer_next;
    lane_mask_t  act_mask;    // lanes frozen for the burst
    lane_mask_t  dec_mask;
    lane_mask_t  cur_mask;
    lane_mask_t  lp_p_next;
    lane_mask_t  lp_n_next;
    logic        all_ready;
    logic        all_empty;
    logic        timer_done;

    always_comb begin
        case (lane_code)
            LANES_1: dec_mask = 4'b0001;
            LANES_2: dec_mask = 4'b0011;
            default: dec_mask = 4'b1111;
        endcase
    end

    // lane count only follows the register while stopped
    assign cur_mask   = (state == ST_STOP) ? dec_mask : act_mask;
    assign all_ready  = ((~fifo_empty & cur_mask) == cur_mask);
    assign all_empty  = ((fifo_empty & cur_mask) == cur_mask);
    assign timer_done = (timer <= timer_t'(1));
    assign lane_state = state;

    always_comb begin
        state_next = state;
        timer_next = timer;
        fifo_pop   = '0;
        case (state)
            ST_STOP: begin
                if (enable && all_ready) begin
                    state_next = ST_HS_RQST;
                    timer_next = tlpx;
                end
            end
            ST_HS_RQST: begin
                if (timer_done) begin
                    state_next = ST_HS_PREP;
                    timer_next = tlpx;
                end else begin
                    timer_next = timer - 1'b1;
                end
            end
            ST_HS_PREP: begin
                if (timer_done) begin
                    state_next = ST_HS_SEND;
                    // first group pops here so it lands right after LP-00
                    if (all_ready) begin
                        fifo_pop = cur_mask;
                    end
                end else begin
                    timer_next = timer - 1'b1;
                end
            end
            ST_HS_SEND: begin
                if (all_ready) begin
                    fifo_pop = cur_mask;
                end else if (all_empty) begin
                    state_next = ST_HS_TRAIL;
                    timer_next = trail;
                end
            end
            ST_HS_TRAIL: begin
                if (timer_done) begin
                    state_next = ST_STOP;
                end else begin
                    timer_next = timer - 1'b1;
                end
            end
            default: state_next = ST_STOP;
        endcase
    end

    // lp levels follow the next state, inactive lanes stay LP-11
    always_comb begin
        lp_p_next = '1;
        lp_n_next = '1;
        case (state_next)
            ST_HS_RQST: lp_p_next = ~cur_mask;
            ST_HS_PREP, ST_HS_SEND, ST_HS_TRAIL: begin
                lp_p_next = ~cur_mask;
                lp_n_next = ~cur_mask;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            state    <= ST_STOP;
            timer    <= '0;
            act_mask <= '1;
            hs_valid <= '0;
            lp_p     <= '1;
            lp_n     <= '1;
        end else begin
            state    <= state_next;
            timer    <= timer_next;
            act_mask <= cur_mask;
            hs_valid <= fifo_pop;
            lp_p     <= lp_p_next;
            lp_n     <= lp_n_next;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (|fifo_pop) begin
            hs_data <= fifo_rdata;
        end
    end

    // a registered group never spills into trail or stop
    assert property (@(posedge clk_sys) disable iff (!rst_n)
        (hs_valid != '0) |-> (state == ST_HS_SEND));

endmodule

//--- rtl/dsi_tx_top.sv
`include "dsi_tx_config.svh"

module dsi_tx_top
    import dsi_tx_pkg::*;
(
    input  logic        clk_sys,
    input  logic        rst_n,

    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic        wb_we,
    input  logic [1:0]  wb_adr,
    input  logic [31:0] wb_dat_w,
    output logic [31:0] wb_dat_r,
    output logic        wb_ack,

    input  pix_word_t   pix_data,
    input  logic        pix_valid,
    output logic        pix_ready,

    output hs_bus_t     hs_data,
    output lane_mask_t  hs_valid,
    output lane_mask_t  lp_p,
    output lane_mask_t  lp_n
);

    logic        enable;
    lane_code_t  lane_code;
    timer_t      tlpx;
    timer_t      trail;
    lane_state_t lane_state;
    hs_bus_t     fifo_wdata;
    lane_mask_t  fifo_push;
    lane_mask_t  fifo_full;
    hs_bus_t     fifo_rdata;
    lane_mask_t  fifo_empty;
    lane_mask_t  fifo_pop;

    dsi_tx_regs dsi_tx_regs_0 (
        .clk_sys    (clk_sys    ),
        .rst_n      (rst_n      ),
        .wb_cyc     (wb_cyc     ),
        .wb_stb     (wb_stb     ),
        .wb_we      (wb_we      ),
        .wb_adr     (wb_adr     ),
        .wb_dat_w   (wb_dat_w   ),
        .wb_dat_r   (wb_dat_r   ),
        .wb_ack     (wb_ack     ),
        .lane_state (lane_state ),
        .enable     (enable     ),
        .lane_code  (lane_code  ),
        .tlpx       (tlpx       ),
        .trail      (trail      )
    );

    dsi_byte_distributor dsi_byte_distributor_0 (
        .clk_sys    (clk_sys    ),
        .rst_n      (rst_n      ),
        .pix_data   (pix_data   ),
        .pix_valid  (pix_valid  ),
        .pix_ready  (pix_ready  ),
        .lane_code  (lane_code  ),  // buffering runs even while disabled
        .fifo_wdata (fifo_wdata ),
        .fifo_push  (fifo_push  ),
        .fifo_full  (fifo_full  )
    );

    for (genvar i = 0; i < `DSI_MAX_LANES; i++) begin : lane_fifos
        dsi_lane_fifo fifo_inst (
            .clk_sys (clk_sys                                            ),
            .rst_n   (rst_n                                              ),
            .wdata   (fifo_wdata[i*`DSI_BYTE_WIDTH +: `DSI_BYTE_WIDTH]   ),
            .push    (fifo_push[i]                                       ),
            .full    (fifo_full[i]                                       ),
            .rdata   (fifo_rdata[i*`DSI_BYTE_WIDTH +: `DSI_BYTE_WIDTH]   ),
            .pop     (fifo_pop[i]                                        ),
            .empty   (fifo_empty[i]                                      )
        );
    end

    dsi_lanes_controller dsi_lanes_controller_0 (
        .clk_sys    (clk_sys    ),
        .rst_n      (rst_n      ),
        .enable     (enable     ),
        .lane_code  (lane_code  ),
        .tlpx       (tlpx       ),
        .trail      (trail      ),
        .fifo_rdata (fifo_rdata ),
        .fifo_empty (fifo_empty ),
        .fifo_pop   (fifo_pop   ),
        .lane_state (lane_state ),
        .hs_data    (hs_data    ),
        .hs_valid   (hs_valid   ),
        .lp_p       (lp_p       ),
        .lp_n       (lp_n       )
    );

endmodule

//--- verification/tb_clock_gen.sv
module tb_clock_gen (
    output logic clk_sys,
    output logic rst_n
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam int RESET_CYCLES = 10;

    initial begin
        clk_sys = 1'b0;
        forever #50 clk_sys = ~clk_sys;    // 100 ns period
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_sys);
        rst_n <= 1'b1;                     // released on a rising edge
    end

endmodule

//--- verification/dsi_tx_tb.sv
`include "dsi_tx_config.svh"

module dsi_tx_tb
    import dsi_tx_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    // about 200 words with start and trail overheads
    localparam int CYCLE_LIMIT = 20000;

    logic        clk_sys;
    logic        rst_n;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [1:0]  wb_adr;
    logic [31:0] wb_dat_w;
    logic [31:0] wb_dat_r;
    logic        wb_ack;
    pix_word_t   pix_data;
    logic        pix_valid;
    logic        pix_ready;
    hs_bus_t     hs_data;
    lane_mask_t  hs_valid;
    lane_mask_t  lp_p;
    lane_mask_t  lp_n;

    integer      seed = 19;
    int unsigned cycle_count = 0;
    lane_byte_t  exp_q [`DSI_MAX_LANES][$];   // expected bytes per lane
    pix_word_t   word_list[$];
    int          words_sent;
    int          cur_lanes;
    logic        cur_enable;
    int          cur_tlpx;
    int          cur_trail;

    // lp sequence tracking on lane 0
    logic [1:0]  lp_prev;
    int          run_rqst;
    int          run_prep;
    int          run_trail;
    logic        in_send;

    tb_clock_gen clock_gen0 (
        .clk_sys (clk_sys),
        .rst_n   (rst_n  )
    );

    dsi_tx_top dut0 (
        .clk_sys   (clk_sys  ),
        .rst_n     (rst_n    ),
        .wb_cyc    (wb_cyc   ),
        .wb_stb    (wb_stb   ),
        .wb_we     (wb_we    ),
        .wb_adr    (wb_adr   ),
        .wb_dat_w  (wb_dat_w ),
        .wb_dat_r  (wb_dat_r ),
        .wb_ack    (wb_ack   ),
        .pix_data  (pix_data ),
        .pix_valid (pix_valid),
        .pix_ready (pix_ready),
        .hs_data   (hs_data  ),
        .hs_valid  (hs_valid ),
        .lp_p      (lp_p     ),
        .lp_n      (lp_n     )
    );

    task automatic report_error(input string msg);
        $display("%0d ns: %s", $time, msg);
        $display("*** FAILED ***");
        $fatal(1, "testbench stopped");
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %0d ns: %s got 0x%0h expected 0x%0h", $time, what, got, exp);
            $display("*** FAILED ***");
            $fatal(1, "value mismatch");
        end
    endtask

    // byte k of the stream lands on lane k mod n
    function automatic void build_expected(input lane_byte_t bytes[$], input int n_lanes);
        for (int k = 0; k < bytes.size(); k++) begin
            exp_q[k % n_lanes].push_back(bytes[k]);
        end
    endfunction

    function automatic int pending_bytes();
        int total;
        total = 0;
        for (int i = 0; i < `DSI_MAX_LANES; i++) begin
            total += exp_q[i].size();
        end
        return total;
    endfunction

    function automatic logic [31:0] ctrl_word(input int lanes, input logic en);
        lane_code_t code;
        case (lanes)
            1:       code = LANES_1;
            2:       code = LANES_2;
            default: code = LANES_4;
        endcase
        return {29'd0, code, en};
    endfunction

    task automatic wb_access(input logic we, input logic [1:0] adr, input logic [31:0] wdata,
                             output logic [31:0] rdata);
        @(posedge clk_sys);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= we;
        wb_adr   <= adr;
        wb_dat_w <= wdata;
        @(posedge clk_sys);
        while (!wb_ack) begin
            @(posedge clk_sys);
        end
        rdata = wb_dat_r;                  // valid while ack is high
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
        @(posedge clk_sys);
        check_value("wb_ack one cycle after ack", wb_ack, 32'd0);
    endtask

    task automatic write_reg(input logic [1:0] adr, input logic [31:0] data);
        logic [31:0] rd_dummy;
        wb_access(1'b1, adr, data, rd_dummy);
    endtask

    task automatic expect_reg(input logic [1:0] adr, input logic [31:0] exp, input string what);
        logic [31:0] got;
        wb_access(1'b0, adr, 32'd0, got);
        check_value(what, got, exp);
    endtask

    // only called while the link is idle
    task automatic configure(input int lanes, input logic en, input int t_lpx, input int t_trail);
        cur_tlpx   = t_lpx;
        cur_trail  = t_trail;
        cur_lanes  = lanes;
        cur_enable = en;
        write_reg(`DSI_REG_TLPX, t_lpx);
        write_reg(`DSI_REG_TRAIL, t_trail);
        write_reg(`DSI_REG_CTRL, ctrl_word(lanes, en));
    endtask

    task automatic make_burst(input int n_words);
        lane_byte_t bytes[$];
        pix_word_t  w;
        word_list.delete();
        words_sent = 0;
        for (int i = 0; i < n_words; i++) begin
            w = $random(seed);
            word_list.push_back(w);
            for (int b = 0; b < 4; b++) begin
                bytes.push_back(w[b*8 +: 8]);
            end
        end
        build_expected(bytes, cur_lanes);
    endtask

    task automatic send_words();
        @(posedge clk_sys);
        foreach (word_list[i]) begin
            pix_data  <= word_list[i];
            pix_valid <= 1'b1;
            @(posedge clk_sys);
            while (!pix_ready) begin
                @(posedge clk_sys);
            end
            words_sent <= words_sent + 1;  // taken on this edge
        end
        pix_valid <= 1'b0;
    endtask

    task automatic wait_drained();
        do begin
            @(posedge clk_sys);
        end while (pending_bytes() != 0);
        do begin
            @(posedge clk_sys);
        end while (lp_p != '1 || lp_n != '1);
        repeat (4) @(posedge clk_sys);
    endtask

    task automatic run_burst(input int lanes, input int n_words, input int t_lpx,
                             input int t_trail);
        configure(lanes, 1'b1, t_lpx, t_trail);
        make_burst(n_words);
        send_words();
        wait_drained();
        expect_reg(`DSI_REG_STATUS, ST_STOP, "status after burst");
        check_value("pix_ready after burst", pix_ready, 32'd1);
    endtask

    // fill the disabled link past capacity, then enable and drain
    task automatic stall_and_drain(input int lanes);
        int cap_words;
        cap_words = `DSI_FIFO_DEPTH * lanes / 4 + 1;   // full FIFOs plus the held word
        configure(lanes, 1'b0, cur_tlpx, cur_trail);
        make_burst(cap_words + 2);
        fork
            send_words();
            begin
                do begin
                    @(posedge clk_sys);
                end while (words_sent < cap_words);
                repeat (20) begin
                    @(posedge clk_sys);
                    check_value("pix_ready with full FIFOs", pix_ready, 32'd0);
                end
                check_value("words taken with full FIFOs", words_sent, cap_words);
                cur_enable = 1'b1;
                write_reg(`DSI_REG_CTRL, ctrl_word(lanes, 1'b1));
            end
        join
        wait_drained();
        check_value("pix_ready after drain", pix_ready, 32'd1);
        expect_reg(`DSI_REG_STATUS, ST_STOP, "status after drain");
    endtask

    always @(posedge clk_sys) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout, the test did not finish within %0d cycles", CYCLE_LIMIT);
            $display("*** FAILED ***");
            $fatal(1, "timeout");
        end
    end

    // compare delivered groups with the reference queues
    always @(posedge clk_sys) begin
        if (rst_n) begin
            if (hs_valid != '0 && !cur_enable) begin
                report_error("hs data was sent while the link was disabled");
            end
            for (int i = 0; i < `DSI_MAX_LANES; i++) begin
                if (hs_valid[i] && i < cur_lanes) begin
                    if (exp_q[i].size() == 0) begin
                        report_error($sformatf("lane %0d sent a byte that was never sent in", i));
                    end
                    check_value($sformatf("lane %0d byte", i), hs_data[i*8 +: 8],
                                exp_q[i].pop_front());
                end
            end
        end
    end

    always @(posedge clk_sys) begin : lp_monitor
        logic [1:0] lp_now;
        lp_now = {lp_p[0], lp_n[0]};
        if (!rst_n) begin
            lp_prev = 2'b11;
        end else begin
            for (int i = 1; i < `DSI_MAX_LANES; i++) begin
                if (i < cur_lanes) begin
                    check_value($sformatf("lane %0d follows lane 0", i),
                                {lp_p[i], lp_n[i], hs_valid[i]}, {lp_now, hs_valid[0]});
                end else begin
                    check_value($sformatf("idle lane %0d", i),
                                {lp_p[i], lp_n[i], hs_valid[i]}, 3'b110);
                end
            end
            if (lp_now != 2'b00) begin
                check_value("hs_valid outside LP-00", hs_valid[0], 32'd0);
            end
            case (lp_now)
                2'b11: begin
                    if (lp_prev == 2'b00) begin
                        if (!in_send) begin
                            report_error("lanes left LP-00 without sending any byte");
                        end
                        check_value("trail cycles", run_trail, cur_trail);
                    end else if (lp_prev == 2'b01) begin
                        report_error("lanes went from LP-01 straight back to LP-11");
                    end
                end
                2'b01: begin
                    if (lp_prev == 2'b11) begin
                        run_rqst = 0;
                    end else if (lp_prev != 2'b01) begin
                        report_error("lanes went from LP-00 to LP-01");
                    end
                    run_rqst++;
                end
                2'b00: begin
                    if (lp_prev == 2'b01) begin
                        check_value("LP-01 cycles", run_rqst, cur_tlpx);
                        run_prep = 0;
                        in_send  = 1'b0;
                    end else if (lp_prev == 2'b11) begin
                        report_error("lanes went from LP-11 to LP-00 without LP-01");
                    end
                    if (hs_valid[0]) begin
                        if (!in_send) begin
                            check_value("LP-00 cycles before first byte", run_prep, cur_tlpx);
                        end
                        in_send   = 1'b1;
                        run_trail = 0;
                    end else if (in_send) begin
                        run_trail++;
                    end else begin
                        run_prep++;
                    end
                end
                default: report_error("lane 0 drove LP-10");
            endcase
            lp_prev = lp_now;
        end
    end

    initial begin
        wb_cyc     = 1'b0;
        wb_stb     = 1'b0;
        wb_we      = 1'b0;
        wb_adr     = 2'd0;
        wb_dat_w   = 32'd0;
        pix_data   = '0;
        pix_valid  = 1'b0;
        cur_lanes  = 4;
        cur_enable = 1'b0;
        cur_tlpx   = 4;
        cur_trail  = 6;
        words_sent = 0;
        @(posedge rst_n);
        @(posedge clk_sys);

        check_value("lp_p after reset", lp_p, 32'hf);
        check_value("lp_n after reset", lp_n, 32'hf);
        check_value("hs_valid after reset", hs_valid, 32'd0);
        check_value("pix_ready after reset", pix_ready, 32'd1);
        expect_reg(`DSI_REG_CTRL, ctrl_word(4, 1'b0), "ctrl reset value");
        expect_reg(`DSI_REG_TLPX, 32'd4, "tlpx reset value");
        expect_reg(`DSI_REG_TRAIL, 32'd6, "trail reset value");
        expect_reg(`DSI_REG_STATUS, ST_STOP, "status reset value");

        configure(2, 1'b0, 3, 5);
        expect_reg(`DSI_REG_TLPX, 32'd3, "tlpx readback");
        expect_reg(`DSI_REG_TRAIL, 32'd5, "trail readback");
        expect_reg(`DSI_REG_CTRL, ctrl_word(2, 1'b0), "ctrl readback");

        run_burst(4, 40, 3, 5);
        run_burst(2, 30, 2, 7);
        run_burst(1, 20, 5, 3);

        stall_and_drain(4);
        stall_and_drain(2);

        $display("*** PASSED ***");
        $finish;
    end

endmodule

//--- dsi_tx.f
+incdir+rtl
rtl/dsi_tx_pkg.sv
rtl/dsi_tx_regs.sv
rtl/dsi_byte_distributor.sv
rtl/dsi_lane_fifo.sv
rtl/dsi_lanes_controller.sv
rtl/dsi_tx_top.sv
verification/tb_clock_gen.sv
verification/dsi_tx_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
    --top-module dsi_tx_tb -f dsi_tx.f -o dsi_tx_sim

status=0
output=$(./obj_dir/dsi_tx_sim 2>&1) || status=$?
printf '%s\n' "$output"

if [ "$status" -eq 0 ] && printf '%s\n' "$output" | grep -qxF '*** PASSED ***'; then
    exit 0
fi
echo "simulation did not pass"
exit 1
